/* verilog/video_pkg.sv */
/*
 * Video subsystem shared definitions
 * Raster geometry, tile map layout, palette size and the packed
 * structs passed between timer, fetcher, line buffer and mixer
 */
package video_pkg;

    // Horizontal geometry in pixel enables
    localparam int H_TOTAL  = 96;
    localparam int H_VIS    = 64;
    localparam int HS_START = 72;
    localparam int HS_LEN   = 8;

    // Vertical geometry in lines
    localparam int V_TOTAL  = 40;
    localparam int V_VIS    = 32;
    localparam int VS_START = 34;
    localparam int VS_LEN   = 2;

    // Tile map and palette
    localparam int MAP_COLS    = 8;
    localparam int PAL_ENTRIES = 256;

    // Raster counters and timing strobes
    typedef struct packed {
        logic [6:0] hdump;
        logic [5:0] vdump;
        logic       lhbl;   // high while visible
        logic       lvbl;   // high while visible
        logic       hs;
        logic       vs;
        logic       hinit;
    } raster_t;

    // Colour 0 is transparent
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] col;
    } pixel_t;

    typedef struct packed {
        logic [3:0]  pal;
        logic [11:0] code;
    } map_word_t;

    // Addr 0..255 palette, 256 control register
    typedef struct packed {
        logic        we;
        logic [8:0]  addr;
        logic [15:0] data;
    } cpu_wr_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

/* verilog/video_timer.sv */
/*
 * Video timer
 * Pixel clock enable at half the clock rate, raster counters,
 * blanking, sync and the line start strobe
 */
`timescale 1ns/1ns

module video_timer import video_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    output logic    pxl_cen,
    output raster_t raster
);

    logic [6:0] h_next;
    logic [5:0] v_next;

    // Counter values after the coming pixel enable
    always_comb begin
        h_next = raster.hdump + 7'd1;
        v_next = raster.vdump;
        if (raster.hdump == 7'(H_TOTAL - 1)) begin
            h_next = '0;
            if (raster.vdump == 6'(V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = raster.vdump + 6'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl_cen      <= 1'b0;
            raster.hdump <= '0;
            raster.vdump <= 6'(V_VIS);
            raster.lhbl  <= 1'b0;
            raster.lvbl  <= 1'b0;
            raster.hs    <= 1'b0;
            raster.vs    <= 1'b0;
            raster.hinit <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
            // Pulse lines up with the enable that sees hdump at 0
            raster.hinit <= ~pxl_cen && (raster.hdump == '0);
            if (pxl_cen) begin
                raster.hdump <= h_next;
                raster.vdump <= v_next;
                raster.lhbl  <= h_next < 7'(H_VIS);
                raster.lvbl  <= v_next < 6'(V_VIS);
                raster.hs    <= (h_next >= 7'(HS_START)) &&
                                (h_next < 7'(HS_START + HS_LEN));
                raster.vs    <= (v_next >= 6'(VS_START)) &&
                                (v_next < 6'(VS_START + VS_LEN));
            end
        end
    end

endmodule

/* verilog/tile_fetch.sv */
/*
 * Tile fetcher
 * On each line start reads eight map words and their graphics rows
 * for the next line and writes the pixels into the line buffer
 */
`timescale 1ns/1ns

module tile_fetch import video_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pxl_cen,
    input  raster_t     raster,
    output logic        ram_cs,
    output logic [4:0]  ram_addr,
    input  map_word_t   ram_data,
    input  logic        ram_ok,
    output logic        rom_cs,
    output logic [14:0] rom_addr,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output logic        wr_en,
    output logic [5:0]  wr_x,
    output pixel_t      wr_pixel
);

    typedef enum logic [1:0] {
        IDLE,
        MAP_RD,
        ROM_RD,
        PIX_WR
    } state_t;

    state_t      state;
    logic [4:0]  line;
    logic [2:0]  tile_col;
    logic [2:0]  pix_cnt;
    logic [3:0]  pal_bank;
    logic [11:0] code;
    logic [31:0] gfx_sr;
    logic [5:0]  next_v;

    // Line being prepared, wraps with the frame
    assign next_v = (raster.vdump == 6'(V_TOTAL - 1)) ? 6'd0 : raster.vdump + 6'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            line     <= '0;
            tile_col <= '0;
            pix_cnt  <= '0;
        end else if (pxl_cen && raster.hinit) begin
            // A late fetch is dropped here and starts over
            line     <= next_v[4:0];
            tile_col <= '0;
            state    <= (next_v < 6'(V_VIS)) ? MAP_RD : IDLE;
        end else begin
            case (state)
                MAP_RD: begin
                    if (ram_ok) begin
                        state <= ROM_RD;
                    end
                end
                ROM_RD: begin
                    if (rom_ok) begin
                        pix_cnt <= '0;
                        state   <= PIX_WR;
                    end
                end
                PIX_WR: begin
                    pix_cnt <= pix_cnt + 3'd1;
                    if (pix_cnt == 3'd7) begin
                        if (tile_col == 3'(MAP_COLS - 1)) begin
                            state <= IDLE;
                        end else begin
                            tile_col <= tile_col + 3'd1;
                            state    <= MAP_RD;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Tile attributes and graphics row
    always_ff @(posedge clk) begin
        if (state == MAP_RD && ram_ok) begin
            pal_bank <= ram_data.pal;
            code     <= ram_data.code;
        end
        if (state == ROM_RD && rom_ok) begin
            gfx_sr <= rom_data;
        end else if (state == PIX_WR) begin
            gfx_sr <= gfx_sr << 4;
        end
    end

    // Addresses only change on state transitions, so they hold under cs
    assign ram_cs   = (state == MAP_RD);
    assign ram_addr = {line[4:3], tile_col};
    assign rom_cs   = (state == ROM_RD);
    assign rom_addr = {code, line[2:0]};

    // Leftmost pixel sits in the top nibble
    assign wr_en        = (state == PIX_WR);
    assign wr_x         = {tile_col, pix_cnt};
    assign wr_pixel.pal = pal_bank;
    assign wr_pixel.col = gfx_sr[31:28];

endmodule

/* verilog/line_buffer.sv */
/*
 * Double-banked line buffer
 * The fetcher fills one bank while the display reads the other,
 * banks swap with the parity of the current line
 */
`timescale 1ns/1ns

module line_buffer import video_pkg::*; (
    input  logic       clk,
    input  logic       wr_en,
    input  logic [5:0] wr_x,
    input  pixel_t     wr_pixel,
    input  logic [5:0] rd_x,
    input  logic       vdump_lsb,
    output pixel_t     rd_pixel
);

    pixel_t mem [2][H_VIS];

    logic wr_bank;
    logic rd_bank;

    // Display bank follows the line, fetch goes to the other one
    assign rd_bank = vdump_lsb;
    assign wr_bank = ~vdump_lsb;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_x] <= wr_pixel;
        end
    end

    // One clock read latency
    always_ff @(posedge clk) begin
        rd_pixel <= mem[rd_bank][rd_x];
    end

endmodule

/* verilog/colour_mixer.sv */
/*
 * Colour mixer
 * CPU-written RGB555 palette and control register, backdrop for
 * transparent pixels, layer enable and blanked 24-bit output
 */
`timescale 1ns/1ns

module colour_mixer import video_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    pxl_cen,
    input  raster_t raster,
    input  pixel_t  pixel,
    input  cpu_wr_t cpu_wr,
    output rgb_t    rgb,
    output logic    lhbl_dly,
    output logic    lvbl_dly
);

    // Entry layout is blue [14:10], green [9:5], red [4:0]
    logic [15:0] pal_ram [PAL_ENTRIES];

    logic [7:0]  backdrop;
    logic        layer_en;
    logic [7:0]  pal_idx;
    logic [15:0] entry;
    logic        lhbl_d1;
    logic        lvbl_d1;

    function automatic logic [7:0] expand5(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    always_ff @(posedge clk) begin
        if (cpu_wr.we && cpu_wr.addr < 9'(PAL_ENTRIES)) begin
            pal_ram[cpu_wr.addr[7:0]] <= cpu_wr.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            backdrop <= '0;
            layer_en <= 1'b0;
        end else if (cpu_wr.we && cpu_wr.addr == 9'(PAL_ENTRIES)) begin
            backdrop <= cpu_wr.data[7:0];
            layer_en <= cpu_wr.data[8];
        end
    end

    // Stage 1, pick the palette index
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_idx <= (layer_en && pixel.col != 4'd0) ? {pixel.pal, pixel.col} : backdrop;
        end
    end

    assign entry = pal_ram[pal_idx];

    // Stage 2, colour out with blanking delayed to match
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            lhbl_d1  <= raster.lhbl;
            lvbl_d1  <= raster.lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            if (lhbl_d1 && lvbl_d1) begin
                rgb.red   <= expand5(entry[4:0]);
                rgb.green <= expand5(entry[9:5]);
                rgb.blue  <= expand5(entry[14:10]);
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

/* verilog/video_top.sv */
/*
 * Tile video subsystem top level
 * Timer, tile fetcher, line buffer and colour mixer
 */
`timescale 1ns/1ns

module video_top import video_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  cpu_wr_t     cpu_wr,
    // Video RAM
    output logic        ram_cs,
    output logic [4:0]  ram_addr,
    input  map_word_t   ram_data,
    input  logic        ram_ok,
    // Graphics ROM
    output logic        rom_cs,
    output logic [14:0] rom_addr,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    // Video out
    output logic        hs,
    output logic        vs,
    output logic        lhbl_dly,
    output logic        lvbl_dly,
    output rgb_t        rgb
);

    logic       pxl_cen;
    raster_t    raster;
    logic       wr_en;
    logic [5:0] wr_x;
    pixel_t     wr_pixel;
    pixel_t     rd_pixel;

    video_timer u_timer (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .raster  (raster)
    );

    tile_fetch u_fetch (
        .clk      (clk),
        .arst_n   (arst_n),
        .pxl_cen  (pxl_cen),
        .raster   (raster),
        .ram_cs   (ram_cs),
        .ram_addr (ram_addr),
        .ram_data (ram_data),
        .ram_ok   (ram_ok),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_pixel (wr_pixel)
    );

    // Display side reads at the current raster position
    line_buffer u_lbuf (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_x      (wr_x),
        .wr_pixel  (wr_pixel),
        .rd_x      (raster.hdump[5:0]),
        .vdump_lsb (raster.vdump[0]),
        .rd_pixel  (rd_pixel)
    );

    colour_mixer u_mixer (
        .clk      (clk),
        .arst_n   (arst_n),
        .pxl_cen  (pxl_cen),
        .raster   (raster),
        .pixel    (rd_pixel),
        .cpu_wr   (cpu_wr),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    assign hs = raster.hs;
    assign vs = raster.vs;

endmodule

/* verification/video_mem_model.sv */
/*
 * Video RAM and graphics ROM models
 * Map contents are loaded by the testbench, ok follows cs after a
 * latency taken from the lat inputs while cs is low
 */
`timescale 1ns/1ns

module video_mem_model import video_pkg::*; (
    input  logic        clk,
    input  logic [2:0]  ram_lat,
    input  logic [2:0]  rom_lat,
    input  logic        ram_cs,
    input  logic [4:0]  ram_addr,
    output map_word_t   ram_data,
    output logic        ram_ok,
    input  logic        rom_cs,
    input  logic [14:0] rom_addr,
    output logic [31:0] rom_data,
    output logic        rom_ok
);

    map_word_t  map_mem [32];
    logic [2:0] ram_wait;
    logic [2:0] rom_wait;
    logic [2:0] ram_cnt;
    logic [2:0] rom_cnt;

    // Graphics row for a {code, row} address, mixes every address bit
    function automatic logic [31:0] gfx_row(input logic [14:0] a);
        logic [31:0] h;
        h = {17'd0, a} * 32'h9e37_79b1;
        return h ^ {a[7:0], a[14:0], a[14:6]};
    endfunction

    // Latency is held for the whole access
    always_ff @(posedge clk) begin
        if (!ram_cs) begin
            ram_cnt  <= '0;
            ram_wait <= ram_lat;
        end else if (ram_cnt != 3'd7) begin
            ram_cnt <= ram_cnt + 3'd1;
        end
        if (!rom_cs) begin
            rom_cnt  <= '0;
            rom_wait <= rom_lat;
        end else if (rom_cnt != 3'd7) begin
            rom_cnt <= rom_cnt + 3'd1;
        end
    end

    assign ram_ok   = ram_cs && (ram_cnt >= ram_wait);
    assign ram_data = map_mem[ram_addr];
    assign rom_ok   = rom_cs && (rom_cnt >= rom_wait);
    assign rom_data = gfx_row(rom_addr);

endmodule

/* verification/video_tb.sv */
/*
 * Testbench for the tile video subsystem
 * Random map, graphics rows and palettes, every visible pixel is
 * compared against a reference built from the memory contents
 */
`timescale 1ns/1ns

module video_tb import video_pkg::*; ();

    localparam int FRAME_CYCLES   = V_TOTAL * H_TOTAL * 2;
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + 1000;

    logic        clk;
    logic        arst_n;
    cpu_wr_t     cpu_wr;
    logic        ram_cs;
    logic [4:0]  ram_addr;
    map_word_t   ram_data;
    logic        ram_ok;
    logic        rom_cs;
    logic [14:0] rom_addr;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic        hs;
    logic        vs;
    logic        lhbl_dly;
    logic        lvbl_dly;
    rgb_t        rgb;
    logic [2:0]  ram_lat;
    logic [2:0]  rom_lat;

    logic [31:0] lfsr = 32'h2fd0;
    map_word_t   map_shadow [32];
    logic [15:0] pal_shadow [PAL_ENTRIES];
    logic [15:0] pal_sets [2][PAL_ENTRIES];
    logic [7:0]  backdrop_sets [2];
    logic [7:0]  backdrop = '0;
    logic        layer_on = 1'b0;
    logic        checking = 1'b0;
    logic        frame_seen = 1'b0;
    logic        hs_q = 1'b0;
    logic        vs_q = 1'b0;
    logic        lhbl_q = 1'b0;
    logic        lvbl_q = 1'b0;
    int          cycles = 0;
    int          frames_checked = 0;
    int          transparent_seen = 0;
    int          hs_count = 0;
    int          vs_count = 0;
    int          line_count = 0;
    int          half_count = 0;

    video_top video_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .cpu_wr   (cpu_wr),
        .ram_cs   (ram_cs),
        .ram_addr (ram_addr),
        .ram_data (ram_data),
        .ram_ok   (ram_ok),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .hs       (hs),
        .vs       (vs),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .rgb      (rgb)
    );

    video_mem_model mem_i (
        .clk      (clk),
        .ram_lat  (ram_lat),
        .rom_lat  (rom_lat),
        .ram_cs   (ram_cs),
        .ram_addr (ram_addr),
        .ram_data (ram_data),
        .ram_ok   (ram_ok),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Pixel the fetcher should have stored for (x, y)
    function automatic pixel_t tile_pixel(input int x, input int y);
        map_word_t   m;
        logic [31:0] row;
        pixel_t      p;
        m = map_shadow[(y / 8) * MAP_COLS + x / 8];
        row = mem_i.gfx_row({m.code, 3'(y % 8)});
        p.pal = m.pal;
        p.col = row[31 - 4 * (x % 8) -: 4];
        return p;
    endfunction

    function automatic rgb_t expected_rgb(input int x, input int y);
        pixel_t      p;
        logic [7:0]  idx;
        logic [15:0] e;
        rgb_t        c;
        p = tile_pixel(x, y);
        idx = (layer_on && p.col != 4'd0) ? {p.pal, p.col} : backdrop;
        e = pal_shadow[idx];
        c.red   = {e[4:0], e[4:2]};
        c.green = {e[9:5], e[9:7]};
        c.blue  = {e[14:10], e[14:12]};
        return c;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t: %s rgb %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_failure($sformatf("Error at %0t: %s is %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t: %s is %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    // Shadows follow every write
    task automatic cpu_write(input logic [8:0] addr, input logic [15:0] data);
        @(posedge clk);
        #2;
        cpu_wr.we   = 1'b1;
        cpu_wr.addr = addr;
        cpu_wr.data = data;
        if (addr < 9'(PAL_ENTRIES)) begin
            pal_shadow[addr[7:0]] = data;
        end else begin
            backdrop = data[7:0];
            layer_on = data[8];
        end
        @(posedge clk);
        #2;
        cpu_wr.we = 1'b0;
    endtask

    task automatic load_palette(input int set, input logic layer);
        for (int i = 0; i < PAL_ENTRIES; i++) begin
            cpu_write(9'(i), pal_sets[set][i]);
        end
        cpu_write(9'(PAL_ENTRIES), {7'd0, layer, backdrop_sets[set]});
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // New memory latencies of 0 to 6 cycles on every clock
    initial begin
        ram_lat = '0;
        rom_lat = '0;
        forever begin
            @(posedge clk);
            #2;
            ram_lat = 3'(rand_bits(3) % 7);
            rom_lat = 3'(rand_bits(3) % 7);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: the run did not finish within %0d clock cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    // Outputs change on the rising edge, so sample on the falling one
    always @(negedge clk) begin : compare
        pixel_t p;
        int     x;
        if (arst_n) begin
            if (hs && !hs_q) begin
                hs_count++;
            end
            if (vs && !vs_q) begin
                vs_count++;
            end
            if (lvbl_dly && !lvbl_q) begin
                if (frame_seen) begin
                    check_count(hs_count, V_TOTAL, "hs pulses per frame");
                    check_count(vs_count, 1, "vs pulses per frame");
                end
                frame_seen = 1'b1;
                hs_count = 0;
                vs_count = 0;
                line_count = 0;
            end
            if (lhbl_dly && lvbl_dly) begin
                // Each pixel lasts two clocks
                if (checking && half_count % 2 == 0) begin
                    x = half_count / 2;
                    p = tile_pixel(x, line_count);
                    if (layer_on && p.col == 4'd0 &&
                        pal_shadow[{p.pal, 4'd0}] != pal_shadow[backdrop]) begin
                        transparent_seen++;
                    end
                    check_rgb(rgb, expected_rgb(x, line_count),
                              $sformatf("pixel (%0d, %0d)", x, line_count));
                end
                half_count++;
            end else begin
                check_rgb(rgb, '0, "blanked output");
                if (lhbl_q && lvbl_q) begin
                    check_count(half_count, 2 * H_VIS, "visible pixel clocks in a line");
                    line_count++;
                    half_count = 0;
                end
            end
            if (!lvbl_dly && lvbl_q) begin
                check_count(line_count, V_VIS, "visible lines per frame");
                if (checking) begin
                    frames_checked++;
                end
            end
        end
        hs_q = hs;
        vs_q = vs;
        lhbl_q = lhbl_dly;
        lvbl_q = lvbl_dly;
    end

    initial begin
        arst_n = 1'b0;
        cpu_wr = '0;
        for (int i = 0; i < 32; i++) begin
            map_shadow[i] = 16'(rand_bits(16));
            mem_i.map_mem[i] = map_shadow[i];
        end
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < PAL_ENTRIES; i++) begin
                pal_sets[s][i] = 16'(rand_bits(15));
            end
            backdrop_sets[s] = 8'(rand_bits(8));
        end
        repeat (10) @(posedge clk);
        #2;
        check_level(ram_cs, 1'b0, "ram_cs after reset");
        check_level(rom_cs, 1'b0, "rom_cs after reset");
        check_level(hs, 1'b0, "hs after reset");
        check_level(vs, 1'b0, "vs after reset");
        check_level(lhbl_dly, 1'b0, "lhbl_dly after reset");
        check_level(lvbl_dly, 1'b0, "lvbl_dly after reset");
        check_rgb(rgb, '0, "output after reset");
        arst_n = 1'b1;

        // Reset leaves the raster in vertical blanking
        load_palette(0, 1'b0);
        checking = 1'b1;
        @(negedge lvbl_dly);
        cpu_write(9'(PAL_ENTRIES), {7'd0, 1'b1, backdrop_sets[0]});
        @(negedge lvbl_dly);
        load_palette(1, 1'b1);
        @(negedge lvbl_dly);
        @(posedge clk);
        #2;
        check_count(frames_checked, 3, "frames compared");
        check_level(transparent_seen > 0, 1'b1, "transparent pixels over a distinct backdrop");
        $display("Regression passed");
        $finish;
    end

endmodule

/* project.f */
verilog/video_pkg.sv
verilog/video_timer.sv
verilog/tile_fetch.sv
verilog/line_buffer.sv
verilog/colour_mixer.sv
verilog/video_top.sv
verification/video_mem_model.sv
verification/video_tb.sv

/* Bender.yml */
package:
  name: tile_video

sources:
  - verilog/video_pkg.sv
  - verilog/video_timer.sv
  - verilog/tile_fetch.sv
  - verilog/line_buffer.sv
  - verilog/colour_mixer.sv
  - verilog/video_top.sv
  - target: test
    files:
      - verification/video_mem_model.sv
      - verification/video_tb.sv
